// ==== list.f ====
src/dcache_pkg.sv
src/cache_way.sv
src/way_select.sv
src/cache_controller.sv
src/assoc_dcache.sv
verification/dcache_tb.sv

// ==== Makefile ====
# Verilator build and run for the two-way data cache testbench

VERILATOR := verilator
VFLAGS    := --binary --assert --timescale 1ns/1ps -j 0
TOP       := dcache_tb
FILELIST  := list.f
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Everything OK

SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/dcache_tb.sv ====
//------------------------------------------------
// Testbench for the two-way data cache
// Block memory with random latency, directed and
// random accesses, checks done by assertions
//------------------------------------------------

`default_nettype none

module dcache_tb
    import dcache_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BLOCK_WORDS = 4;
    localparam int SETS        = 16;
    localparam int OFF_W       = $clog2(BLOCK_WORDS);
    localparam int IDX_W       = $clog2(SETS);
    localparam int TAG_W       = WORD_W - 2 - OFF_W - IDX_W;
    localparam int BLK_W       = BLOCK_WORDS * WORD_W;
    localparam int WAIT_LIMIT  = 40;

    logic              clk       = 1'b0;
    logic              rst_n     = 1'b0;
    logic              load      = 1'b0;
    logic              store     = 1'b0;
    logic [WORD_W-1:0] addr      = '0;
    logic [WORD_W-1:0] wd        = '0;
    logic [BLK_W-1:0]  memdata   = '0;
    logic              mem_ready = 1'b0;
    logic [WORD_W-1:0] rd;
    logic              stall;
    logic              memread;
    logic              memwrite;
    logic [WORD_W-1:0] memaddr;
    logic [WORD_W-1:0] memwd;

    // Expectations for the access in flight
    logic              miss_expected   = 1'b0;
    logic [WORD_W-1:0] expected_rd     = '0;
    logic [WORD_W-1:0] exp_addr        = '0;
    logic [WORD_W-1:0] exp_wd          = '0;
    int                read_count      = 0;
    int                write_count     = 0;
    int                reads_at_start  = 0;
    int                writes_at_start = 0;

    // Memory model with stored words over the fill pattern
    integer            seed       = 32'h918851c6;
    logic [WORD_W-1:0] stored [logic [WORD_W-3:0]];
    logic              mem_busy   = 1'b0;
    int                delay_left = 0;

    // Reference tags with index 0 as way 1
    logic              tag_valid [2][SETS];
    logic [TAG_W-1:0]  tag_held  [2][SETS];

    always #20 clk = ~clk;

    assoc_dcache #(
        .BLOCK_WORDS (BLOCK_WORDS),
        .SETS        (SETS)
    ) i_assoc_dcache (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load),
        .store     (store),
        .addr      (addr),
        .wd        (wd),
        .memdata   (memdata),
        .mem_ready (mem_ready),
        .rd        (rd),
        .stall     (stall),
        .memread   (memread),
        .memwrite  (memwrite),
        .memaddr   (memaddr),
        .memwd     (memwd)
    );

    //------------------------------------------------
    // Failure reporting
    //------------------------------------------------

    task automatic abort_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic stop_on_mismatch(input string msg);
        $display("mismatch at %0t: %s", $time, msg);
        abort_run();
    endtask

    task automatic stop_on_error(input string msg);
        $display("error: %s", msg);
        abort_run();
    endtask

    //------------------------------------------------
    // Memory contents and reference tags
    //------------------------------------------------

    function automatic logic [WORD_W-1:0] backing_word(input logic [WORD_W-1:0] a);
        logic [WORD_W-3:0] waddr;
        waddr = a[WORD_W-1:2];
        if (stored.exists(waddr)) begin
            return stored[waddr];
        end
        return ({2'b00, waddr} * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    // Word 0 in the most significant slot
    function automatic logic [BLK_W-1:0] backing_block(input logic [WORD_W-1:0] a);
        logic [BLK_W-1:0]  blk;
        logic [WORD_W-1:0] base;
        base = {a[WORD_W-1:2+OFF_W], {(2+OFF_W){1'b0}}};
        blk  = '0;
        for (int k = 0; k < BLOCK_WORDS; k++) begin
            blk[(BLOCK_WORDS-1-k)*WORD_W +: WORD_W] = backing_word(base + 32'(k * 4));
        end
        return blk;
    endfunction

    function automatic logic predict_hit(input logic [WORD_W-1:0] a);
        logic [IDX_W-1:0] s;
        logic [TAG_W-1:0] t;
        s = a[2+OFF_W +: IDX_W];
        t = a[WORD_W-1 -: TAG_W];
        return (tag_valid[0][s] && tag_held[0][s] == t)
            || (tag_valid[1][s] && tag_held[1][s] == t);
    endfunction

    // Only free way takes the block, else way 1
    function automatic void record_fill(input logic [WORD_W-1:0] a);
        logic [IDX_W-1:0] s;
        int               victim;
        s      = a[2+OFF_W +: IDX_W];
        victim = (tag_valid[0][s] && !tag_valid[1][s]) ? 1 : 0;
        tag_valid[victim][s] = 1'b1;
        tag_held[victim][s]  = a[WORD_W-1 -: TAG_W];
    endfunction

    // Answers a held strobe after 1 to 4 cycles
    always @(negedge clk) begin
        if (mem_ready) begin
            mem_ready <= 1'b0;
            mem_busy = 1'b0;
        end else if (memread || memwrite) begin
            if (!mem_busy) begin
                mem_busy   = 1'b1;
                delay_left = $random(seed) & 3;
            end
            if (delay_left == 0) begin
                mem_ready <= 1'b1;
                if (memread) begin
                    memdata <= backing_block(memaddr);
                end else begin
                    stored[memaddr[WORD_W-1:2]] = memwd;
                end
            end else begin
                delay_left--;
            end
        end
    end

    always @(posedge clk) begin
        if (memread && mem_ready) begin
            read_count <= read_count + 1;
        end
        if (memwrite && mem_ready) begin
            write_count <= write_count + 1;
        end
    end

    //------------------------------------------------
    // Assertions
    //------------------------------------------------

    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !stall && !memread && !memwrite)
        else stop_on_mismatch("stall or a memory strobe high during reset");
    a_after_reset: assert property (@(posedge clk) !rst_n |=> !stall && !memread && !memwrite)
        else stop_on_mismatch("stall or a memory strobe high right after reset");
    a_read_on_miss: assert property (@(posedge clk) disable iff (!rst_n)
        memread |-> miss_expected && memaddr == (exp_addr & ~32'(BLOCK_WORDS * 4 - 1)))
        else stop_on_mismatch($sformatf("memread, memaddr %h, load of %h", memaddr, exp_addr));
    a_write_data: assert property (@(posedge clk) disable iff (!rst_n)
        memwrite |-> store && memaddr == exp_addr && memwd == exp_wd)
        else stop_on_mismatch($sformatf("memwrite %h/%h, want %h/%h",
                                        memaddr, memwd, exp_addr, exp_wd));
    a_load_data: assert property (@(posedge clk) disable iff (!rst_n)
        load && !stall |-> rd == expected_rd)
        else stop_on_mismatch($sformatf("rd %h, want %h at %h", rd, expected_rd, addr));
    a_hit_no_stall: assert property (@(posedge clk) disable iff (!rst_n)
        load && !miss_expected |-> !stall)
        else stop_on_mismatch($sformatf("stall on a load hit at %h", addr));
    a_miss_fetched: assert property (@(posedge clk) disable iff (!rst_n)
        load && !stall && miss_expected |-> read_count != reads_at_start)
        else stop_on_mismatch($sformatf("load miss at %h done without memread", addr));
    a_store_written: assert property (@(posedge clk) disable iff (!rst_n)
        store && !stall |-> write_count != writes_at_start)
        else stop_on_mismatch($sformatf("store to %h done without memwrite", addr));

    //------------------------------------------------
    // Stimulus
    //------------------------------------------------

    // Stall is read mid-cycle and holds until the next rising edge
    task automatic wait_for_release(input string what);
        int   cycles;
        logic stalled;
        cycles  = 0;
        stalled = 1'b1;
        while (stalled) begin
            #1;
            stalled = stall;
            @(negedge clk);
            cycles++;
            if (stalled && cycles > WAIT_LIMIT) begin
                stop_on_error({what, " never finished, stall stayed high"});
            end
        end
    endtask

    task automatic run_load(input logic [WORD_W-1:0] a);
        miss_expected  = !predict_hit(a);
        expected_rd    = backing_word(a);
        exp_addr       = a;
        reads_at_start = read_count;
        addr           = a;
        load           = 1'b1;
        wait_for_release($sformatf("load from %h", a));
        load = 1'b0;
        if (miss_expected) begin
            record_fill(a);
        end
    endtask

    // Stores never allocate and leave the reference tags alone
    task automatic run_store(input logic [WORD_W-1:0] a, input logic [WORD_W-1:0] data);
        miss_expected   = 1'b0;
        exp_addr        = a;
        exp_wd          = data;
        writes_at_start = write_count;
        addr            = a;
        wd              = data;
        store           = 1'b1;
        wait_for_release($sformatf("store to %h", a));
        store = 1'b0;
    endtask

    initial begin
        logic [WORD_W-1:0] r;
        logic [WORD_W-1:0] a;
        for (int w = 0; w < 2; w++) begin
            for (int s = 0; s < SETS; s++) begin
                tag_valid[w][s] = 1'b0;
                tag_held[w][s]  = '0;
            end
        end
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Cold miss, then hits across the block
        run_load(32'h0000_0148);
        run_load(32'h0000_0140);
        run_load(32'h0000_0144);
        run_load(32'h0000_014c);

        // A store hit also updates the way
        run_store(32'h0000_0144, 32'hcafe_0001);
        run_load(32'h0000_0144);
        run_store(32'h0000_2254, 32'hbeef_0002);
        run_load(32'h0000_2254);

        // Three tags in set 7 where the third evicts way 1
        run_load(32'h0000_0170);
        run_load(32'h0000_0274);
        run_load(32'h0000_0178);
        run_load(32'h0000_027c);
        run_load(32'h0000_0370);
        run_load(32'h0000_0270);
        run_load(32'h0000_0170);

        // Random mix over four sets and four tags
        for (int n = 0; n < 300; n++) begin
            r = $random(seed);
            a = {22'h0d1, r[9:8], 2'b00, r[5:4], r[3:2], 2'b00};
            if (r[13:12] == 2'b00) begin
                run_store(a, $random(seed));
            end else begin
                run_load(a);
            end
        end

        repeat (2) @(negedge clk);
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/assoc_dcache.sv ====
//------------------------------------------------
// Two-way set-associative data cache
// Write-through, no write allocate, block refill
// from a block-wide memory on a load miss
//------------------------------------------------

`default_nettype none

module assoc_dcache
    import dcache_pkg::*;
#(
    parameter int BLOCK_WORDS = 4,
    parameter int SETS        = 16
) (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           load,
    input  wire                           store,
    input  wire  [WORD_W-1:0]             addr,
    input  wire  [WORD_W-1:0]             wd,
    input  wire  [BLOCK_WORDS*WORD_W-1:0] memdata,
    input  wire                           mem_ready,
    output logic [WORD_W-1:0]             rd,
    output logic                          stall,
    output logic                          memread,
    output logic                          memwrite,
    output logic [WORD_W-1:0]             memaddr,
    output logic [WORD_W-1:0]             memwd
);

    localparam int OFF_W = $clog2(BLOCK_WORDS);
    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = WORD_W - 2 - OFF_W - IDX_W;
    localparam int BLK_W = BLOCK_WORDS * WORD_W;

    access_t          access;
    ctrl_state_t      state;
    logic             hit;
    logic             refill;
    logic             store_done;

    // Per-way lookup and write enables
    logic             w1_valid;
    logic             w2_valid;
    logic [TAG_W-1:0] w1_tag;
    logic [TAG_W-1:0] w2_tag;
    logic [BLK_W-1:0] w1_block;
    logic [BLK_W-1:0] w2_block;
    logic             w1_refill_en;
    logic             w2_refill_en;
    logic             w1_update_en;
    logic             w2_update_en;

    // Store wins if both strobes are up
    assign access = store ? ACC_STORE : (load ? ACC_LOAD : ACC_NONE);

    cache_way #(
        .BLOCK_WORDS (BLOCK_WORDS),
        .SETS        (SETS)
    ) i_way1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .addr      (addr),
        .refill_en (w1_refill_en),
        .blockin   (memdata),
        .update_en (w1_update_en && store_done),
        .wd        (wd),
        .way_valid (w1_valid),
        .way_tag   (w1_tag),
        .way_block (w1_block)
    );

    cache_way #(
        .BLOCK_WORDS (BLOCK_WORDS),
        .SETS        (SETS)
    ) i_way2 (
        .clk       (clk),
        .rst_n     (rst_n),
        .addr      (addr),
        .refill_en (w2_refill_en),
        .blockin   (memdata),
        .update_en (w2_update_en && store_done),
        .wd        (wd),
        .way_valid (w2_valid),
        .way_tag   (w2_tag),
        .way_block (w2_block)
    );

    way_select #(
        .BLOCK_WORDS (BLOCK_WORDS),
        .SETS        (SETS)
    ) i_way_select (
        .addr         (addr),
        .refill       (refill),
        .w1_valid     (w1_valid),
        .w1_tag       (w1_tag),
        .w1_block     (w1_block),
        .w2_valid     (w2_valid),
        .w2_tag       (w2_tag),
        .w2_block     (w2_block),
        .access       (access),
        .hit          (hit),
        .w1_refill_en (w1_refill_en),
        .w2_refill_en (w2_refill_en),
        .w1_update_en (w1_update_en),
        .w2_update_en (w2_update_en),
        .rd           (rd)
    );

    cache_controller i_cache_controller (
        .clk        (clk),
        .rst_n      (rst_n),
        .access     (access),
        .hit        (hit),
        .mem_ready  (mem_ready),
        .state      (state),
        .stall      (stall),
        .memread    (memread),
        .memwrite   (memwrite),
        .refill     (refill),
        .store_done (store_done)
    );

    // Word address on a store, block-aligned address on a refill
    assign memaddr = (state == S_STORE) ? addr
                                        : {addr[WORD_W-1:2+OFF_W], {(2+OFF_W){1'b0}}};
    assign memwd   = wd;

endmodule

`default_nettype wire

// ==== src/cache_controller.sv ====
//------------------------------------------------
// Data cache controller
// FSM sequencing block refills and write-through
// stores, driving stall and the memory strobes
//------------------------------------------------

`default_nettype none

module cache_controller
    import dcache_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,
    input  wire  access_t    access,
    input  wire              hit,
    input  wire              mem_ready,
    output ctrl_state_t      state,
    output logic             stall,
    output logic             memread,
    output logic             memwrite,
    output logic             refill,
    output logic             store_done
);

    ctrl_state_t state_d;

    // Set for the cycle after a finished store
    logic        store_ack_q;

    //------------------------------------------------
    // State register
    //------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= S_IDLE;
            store_ack_q <= 1'b0;
        end else begin
            state       <= state_d;
            store_ack_q <= store_done;
        end
    end

    //------------------------------------------------
    // Next state and outputs
    //------------------------------------------------

    always_comb begin
        state_d    = state;
        stall      = 1'b0;
        memread    = 1'b0;
        memwrite   = 1'b0;
        refill     = 1'b0;
        store_done = 1'b0;

        unique case (state)
            S_IDLE: begin
                if (access == ACC_LOAD && !hit) begin
                    // Load miss, stall in the request cycle
                    stall   = 1'b1;
                    state_d = S_REFILL;
                end else if (access == ACC_STORE && !store_ack_q) begin
                    // New store
                    // still held in the cycle after its write, so skip it then
                    stall   = 1'b1;
                    state_d = S_STORE;
                end
            end

            S_REFILL: begin
                stall   = 1'b1;
                memread = 1'b1;
                // Block arrives with mem_ready
                if (mem_ready) begin
                    refill  = 1'b1;
                    state_d = S_IDLE;
                end
            end

            S_STORE: begin
                stall    = 1'b1;
                memwrite = 1'b1;
                // Write accepted, cached copy updated on this edge
                if (mem_ready) begin
                    store_done = 1'b1;
                    state_d    = S_IDLE;
                end
            end

            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/way_select.sv ====
//------------------------------------------------
// Way combining logic
// Tag compare for both ways, refill way choice,
// store update enables and the read word mux
//------------------------------------------------

`default_nettype none

module way_select
    import dcache_pkg::*;
#(
    parameter int BLOCK_WORDS = 4,
    parameter int SETS        = 16
) (
    input  wire  [WORD_W-1:0]             addr,
    input  wire                           refill,
    input  wire                           w1_valid,
    input  wire  [WORD_W-3-$clog2(BLOCK_WORDS)-$clog2(SETS):0] w1_tag,
    input  wire  [BLOCK_WORDS*WORD_W-1:0] w1_block,
    input  wire                           w2_valid,
    input  wire  [WORD_W-3-$clog2(BLOCK_WORDS)-$clog2(SETS):0] w2_tag,
    input  wire  [BLOCK_WORDS*WORD_W-1:0] w2_block,
    input  wire  access_t                 access,
    output logic                          hit,
    output logic                          w1_refill_en,
    output logic                          w2_refill_en,
    output logic                          w1_update_en,
    output logic                          w2_update_en,
    output logic [WORD_W-1:0]             rd
);

    localparam int OFF_W = $clog2(BLOCK_WORDS);
    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = WORD_W - 2 - OFF_W - IDX_W;
    localparam int BLK_W = BLOCK_WORDS * WORD_W;

    logic [TAG_W-1:0] addr_tag;
    logic [OFF_W-1:0] word_slot;
    logic             w1_hit;
    logic             w2_hit;
    logic [BLK_W-1:0] hit_block;

    assign addr_tag  = addr[WORD_W-1 -: TAG_W];
    // Offset 0 maps to the most significant word
    assign word_slot = OFF_W'(BLOCK_WORDS - 1) - addr[2 +: OFF_W];

    // Tag compare, only a valid way can hit
    assign w1_hit = w1_valid && (w1_tag == addr_tag);
    assign w2_hit = w2_valid && (w2_tag == addr_tag);
    assign hit    = w1_hit || w2_hit;

    // Refill target
    always_comb begin
        w1_refill_en = 1'b0;
        w2_refill_en = 1'b0;
        if (refill) begin
            if (hit) begin
                // Rewrite the way already holding the tag
                w1_refill_en = w1_hit;
                w2_refill_en = w2_hit;
            end else if (w1_valid ^ w2_valid) begin
                // Exactly one way free
                w1_refill_en = !w1_valid;
                w2_refill_en = !w2_valid;
            end else begin
                // Both free or both taken
                w1_refill_en = 1'b1;
            end
        end
    end

    // Word update only for a store that hits
    assign w1_update_en = (access == ACC_STORE) && w1_hit;
    assign w2_update_en = (access == ACC_STORE) && w2_hit;

    // Hit block, then the addressed word
    assign hit_block = w1_hit ? w1_block : w2_block;
    assign rd        = hit_block[word_slot*WORD_W +: WORD_W];

endmodule

`default_nettype wire

// ==== src/cache_way.sv ====
//------------------------------------------------
// Data cache way
// Valid bits, tags and blocks for every set, read
// asynchronously by the set index of addr
// Whole-block refill or single-word store update
//------------------------------------------------

`default_nettype none

module cache_way
    import dcache_pkg::*;
#(
    parameter int BLOCK_WORDS = 4,
    parameter int SETS        = 16
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire  [WORD_W-1:0]            addr,
    input  wire                          refill_en,
    input  wire  [BLOCK_WORDS*WORD_W-1:0] blockin,
    input  wire                          update_en,
    input  wire  [WORD_W-1:0]            wd,
    output logic                         way_valid,
    output logic [WORD_W-3-$clog2(BLOCK_WORDS)-$clog2(SETS):0] way_tag,
    output logic [BLOCK_WORDS*WORD_W-1:0] way_block
);

    // Address split is byte offset, word offset, set index, tag
    localparam int OFF_W = $clog2(BLOCK_WORDS);
    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = WORD_W - 2 - OFF_W - IDX_W;
    localparam int BLK_W = BLOCK_WORDS * WORD_W;

    logic [SETS-1:0]  valid_q;
    logic [TAG_W-1:0] tag_mem   [SETS];
    logic [BLK_W-1:0] block_mem [SETS];

    logic [IDX_W-1:0] set_idx;
    logic [TAG_W-1:0] addr_tag;
    logic [OFF_W-1:0] word_slot;

    assign set_idx  = addr[2+OFF_W +: IDX_W];
    assign addr_tag = addr[WORD_W-1 -: TAG_W];
    // Word 0 sits in the top bits of the block
    assign word_slot = OFF_W'(BLOCK_WORDS - 1) - addr[2 +: OFF_W];

    // Valid bits, cleared on reset, set by a refill
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (refill_en) begin
            valid_q[set_idx] <= 1'b1;
        end
    end

    // Tag and block storage
    always_ff @(posedge clk) begin
        if (refill_en) begin
            tag_mem[set_idx]   <= addr_tag;
            block_mem[set_idx] <= blockin;
        end else if (update_en) begin
            // Store hit, tag stays as is
            block_mem[set_idx][word_slot*WORD_W +: WORD_W] <= wd;
        end
    end

    // Asynchronous read of the indexed set
    assign way_valid = valid_q[set_idx];
    assign way_tag   = tag_mem[set_idx];
    assign way_block = block_mem[set_idx];

endmodule

`default_nettype wire

// ==== src/dcache_pkg.sv ====
//------------------------------------------------
// Data cache shared definitions
// Word width, controller states and the decoded
// access kind used across the cache blocks
//------------------------------------------------

`default_nettype none

package dcache_pkg;

    // Data and address word width
    localparam int WORD_W = 32;

    // Controller states
    typedef enum logic [1:0] {
        S_IDLE   = 2'd0,
        S_REFILL = 2'd1,
        S_STORE  = 2'd2
    } ctrl_state_t;

    // Access kind from the load and store strobes
    typedef enum logic [1:0] {
        ACC_NONE  = 2'd0,
        ACC_LOAD  = 2'd1,
        ACC_STORE = 2'd2
    } access_t;

endpackage

`default_nettype wire
